/* ex_alu.sv */
`default_nettype none

module ex_alu import ex_pkg::*; (
    input  wire alu_op_e     alu_op,
    input  wire branch_op_e  branch_alu_op,
    input  wire word_t       in1,
    input  wire word_t       in2,
    input  wire word_t       cmp1,
    input  wire word_t       cmp2,
    output word_t            result,
    output logic             taken
);

    logic [4:0] shamt;
    word_t      sum;
    logic       eq;
    logic       lt_s;
    logic       lt_u;

    assign shamt = in2[4:0];
    assign sum   = in1 + in2;

    always_comb begin
        case (alu_op)
            ALU_ADD:      result = sum;
            ALU_SUB:      result = in1 - in2;
            ALU_SLL:      result = in1 << shamt;
            ALU_SLT:      result = {31'b0, $signed(in1) < $signed(in2)};
            ALU_SLTU:     result = {31'b0, in1 < in2};
            ALU_XOR:      result = in1 ^ in2;
            ALU_SRL:      result = in1 >> shamt;
            ALU_SRA:      result = $signed(in1) >>> shamt;
            ALU_OR:       result = in1 | in2;
            ALU_AND:      result = in1 & in2;
            ALU_CP_IN2:   result = in2;
            // Jump target has bit 0 cleared
            ALU_JALR_ADD: result = sum & ~32'd1;
            ALU_CSRRC:    result = in1 & ~in2;
            default:      result = sum;
        endcase
    end

    // Comparator works on the raw register operands
    assign eq   = (cmp1 == cmp2);
    assign lt_s = ($signed(cmp1) < $signed(cmp2));
    assign lt_u = (cmp1 < cmp2);

    always_comb begin
        case (branch_alu_op)
            BR_BEQ:     taken = eq;
            BR_BNE:     taken = !eq;
            BR_BLT:     taken = lt_s;
            BR_BGE:     taken = !lt_s;
            BR_BLTU:    taken = lt_u;
            BR_BGEU:    taken = !lt_u;
            BR_JUMP:    taken = 1'b1;
            BR_NO_JUMP: taken = 1'b0;
            default:    taken = 1'b0;
        endcase
    end

endmodule

`default_nettype wire

/* ex_ctrl.sv */
`default_nettype none

module ex_ctrl import ex_pkg::*; (
    input  wire opcode_e     opcode,
    input  wire logic [2:0]  funct3,
    input  wire logic [6:0]  funct7,
    input  wire word_t       data1,
    input  wire word_t       data2,
    input  wire word_t       pc,
    input  wire word_t       imm,
    input  wire word_t       z_,
    output word_t            in1,
    output word_t            in2,
    output branch_op_e       branch_alu_op,
    output alu_op_e          alu_op
);

    // ALU input selection
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC, OP_JAL, OP_BRANCH: begin
                in1 = pc;
                in2 = imm;
            end
            OP_JALR, OP_LOAD, OP_STORE, OP_I_TYPE: begin
                in1 = data1;
                in2 = imm;
            end
            OP_R_TYPE: begin
                in1 = data1;
                in2 = data2;
            end
            OP_SYSTEM: begin
                in1 = z_;
                // funct3 bit 2 picks the CSR immediate form
                in2 = funct3[2] ? imm : data1;
            end
            default: begin
                in1 = '0;
                in2 = '0;
            end
        endcase
    end

    // Branch comparator op
    always_comb begin
        case (opcode)
            OP_JAL, OP_JALR: branch_alu_op = BR_JUMP;
            OP_BRANCH:       branch_alu_op = branch_op_e'(funct3);
            default:         branch_alu_op = BR_NO_JUMP;
        endcase
    end

    // ALU op
    always_comb begin
        case (opcode)
            OP_LUI:  alu_op = ALU_CP_IN2;
            OP_JALR: alu_op = ALU_JALR_ADD;
            OP_R_TYPE, OP_I_TYPE: begin
                case (funct3)
                    // SUB only exists in register form
                    3'b000: begin
                        if (opcode == OP_R_TYPE)
                            alu_op = alu_op_e'({funct7[5], funct3});
                        else
                            alu_op = ALU_ADD;
                    end
                    // SRL or SRA in both forms
                    3'b101:  alu_op = alu_op_e'({funct7[5], funct3});
                    default: alu_op = alu_op_e'({1'b0, funct3});
                endcase
            end
            OP_SYSTEM: begin
                case (funct3[1:0])
                    2'b01:   alu_op = ALU_CP_IN2;
                    2'b10:   alu_op = ALU_OR;
                    2'b11:   alu_op = ALU_CSRRC;
                    default: alu_op = ALU_ADD;
                endcase
            end
            // AUIPC, JAL, branches, loads and stores add
            default: alu_op = ALU_ADD;
        endcase
    end

endmodule

`default_nettype wire

/* ex_issue.sv */
`default_nettype none

module ex_issue import ex_pkg::*; (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        in_req,
    input  wire word_t       in_instr,
    input  wire word_t       in_pc,
    input  wire word_t       in_rs1,
    input  wire word_t       in_rs2,
    input  wire word_t       in_csr,
    input  wire logic        full,
    output logic             in_ack,
    output logic             push,
    output opcode_e          q_opcode,
    output logic [2:0]       q_funct3,
    output logic [6:0]       q_funct7,
    output word_t            q_pc,
    output word_t            q_data1,
    output word_t            q_data2,
    output word_t            q_imm,
    output word_t            q_z
);

    typedef enum logic {
        IDLE,
        ACKED
    } state_e;

    state_e  state;
    opcode_e opcode;
    word_t   imm;
    logic    accept;

    assign opcode = opcode_e'(in_instr[6:0]);

    // Immediate by instruction format
    always_comb begin
        case (opcode)
            OP_LUI, OP_AUIPC:
                imm = {in_instr[31:12], 12'b0};
            OP_JAL:
                imm = {{11{in_instr[31]}}, in_instr[31], in_instr[19:12],
                       in_instr[20], in_instr[30:21], 1'b0};
            OP_JALR, OP_LOAD, OP_I_TYPE:
                imm = {{20{in_instr[31]}}, in_instr[31:20]};
            OP_STORE:
                imm = {{20{in_instr[31]}}, in_instr[31:25], in_instr[11:7]};
            OP_BRANCH:
                imm = {{19{in_instr[31]}}, in_instr[31], in_instr[7],
                       in_instr[30:25], in_instr[11:8], 1'b0};
            // CSR immediate is the zero-extended rs1 field
            OP_SYSTEM:
                imm = {27'b0, in_instr[19:15]};
            default:
                imm = '0;
        endcase
    end

    // New request, previous one fully released, room in the queue
    assign accept = (state == IDLE) && in_req && !full;
    assign in_ack = (state == ACKED);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
            push  <= 1'b0;
        end else begin
            push <= accept;
            case (state)
                IDLE:    if (accept) state <= ACKED;
                ACKED:   if (!in_req) state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Decoded fields are held for the queue write on the next edge
    always_ff @(posedge clk) begin
        if (accept) begin
            q_opcode <= opcode;
            q_funct3 <= in_instr[14:12];
            q_funct7 <= in_instr[31:25];
            q_pc     <= in_pc;
            q_data1  <= in_rs1;
            q_data2  <= in_rs2;
            q_imm    <= imm;
            q_z      <= in_csr;
        end
    end

endmodule

`default_nettype wire

/* ex_pkg.sv */
`default_nettype none

package ex_pkg;

    // Data word for pc, operands, immediates and results
    typedef logic [31:0] word_t;

    // Supported RV32I major opcodes
    typedef enum logic [6:0] {
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,
        OP_JALR   = 7'b1100111,
        OP_BRANCH = 7'b1100011,
        OP_LOAD   = 7'b0000011,
        OP_STORE  = 7'b0100011,
        OP_I_TYPE = 7'b0010011,
        OP_R_TYPE = 7'b0110011,
        OP_SYSTEM = 7'b1110011
    } opcode_e;

    // ALU operations, low three bits follow funct3 for the RV32I ops
    typedef enum logic [3:0] {
        ALU_ADD      = 4'b0000,
        ALU_SLL      = 4'b0001,
        ALU_SLT      = 4'b0010,
        ALU_SLTU     = 4'b0011,
        ALU_XOR      = 4'b0100,
        ALU_SRL      = 4'b0101,
        ALU_OR       = 4'b0110,
        ALU_AND      = 4'b0111,
        ALU_SUB      = 4'b1000,
        ALU_CP_IN2   = 4'b1001,
        ALU_JALR_ADD = 4'b1010,
        ALU_CSRRC    = 4'b1011,
        ALU_SRA      = 4'b1101
    } alu_op_e;

    // Branch comparator ops, conditional ones reuse the funct3 code
    typedef enum logic [2:0] {
        BR_BEQ     = 3'b000,
        BR_BNE     = 3'b001,
        BR_JUMP    = 3'b010,
        BR_NO_JUMP = 3'b011,
        BR_BLT     = 3'b100,
        BR_BGE     = 3'b101,
        BR_BLTU    = 3'b110,
        BR_BGEU    = 3'b111
    } branch_op_e;

    // Decoded instruction queue between intake and execute
    localparam int QUEUE_DEPTH = 2;
    localparam int QUEUE_PTR_W = $clog2(QUEUE_DEPTH);
    // Count runs from 0 to QUEUE_DEPTH inclusive
    localparam int QUEUE_CNT_W = $clog2(QUEUE_DEPTH + 1);

endpackage

`default_nettype wire

/* ex_queue.sv */
`default_nettype none

module ex_queue import ex_pkg::*; (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire logic        push,
    input  wire logic        pop,
    input  wire opcode_e     q_opcode,
    input  wire logic [2:0]  q_funct3,
    input  wire logic [6:0]  q_funct7,
    input  wire word_t       q_pc,
    input  wire word_t       q_data1,
    input  wire word_t       q_data2,
    input  wire word_t       q_imm,
    input  wire word_t       q_z,
    output opcode_e          h_opcode,
    output logic [2:0]       h_funct3,
    output logic [6:0]       h_funct7,
    output word_t            h_pc,
    output word_t            h_data1,
    output word_t            h_data2,
    output word_t            h_imm,
    output word_t            h_z,
    output logic             full,
    output logic             empty
);

    opcode_e    mem_opcode [QUEUE_DEPTH];
    logic [2:0] mem_funct3 [QUEUE_DEPTH];
    logic [6:0] mem_funct7 [QUEUE_DEPTH];
    word_t      mem_pc     [QUEUE_DEPTH];
    word_t      mem_data1  [QUEUE_DEPTH];
    word_t      mem_data2  [QUEUE_DEPTH];
    word_t      mem_imm    [QUEUE_DEPTH];
    word_t      mem_z      [QUEUE_DEPTH];

    logic [QUEUE_PTR_W-1:0] wr_ptr;
    logic [QUEUE_PTR_W-1:0] rd_ptr;
    logic [QUEUE_CNT_W-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == QUEUE_CNT_W'(QUEUE_DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= (wr_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            if (do_pop)
                rd_ptr <= (rd_ptr == QUEUE_PTR_W'(QUEUE_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            // Simultaneous push and pop leaves the count unchanged
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem_opcode[wr_ptr] <= q_opcode;
            mem_funct3[wr_ptr] <= q_funct3;
            mem_funct7[wr_ptr] <= q_funct7;
            mem_pc[wr_ptr]     <= q_pc;
            mem_data1[wr_ptr]  <= q_data1;
            mem_data2[wr_ptr]  <= q_data2;
            mem_imm[wr_ptr]    <= q_imm;
            mem_z[wr_ptr]      <= q_z;
        end
    end

    // Head entry, valid while not empty
    assign h_opcode = mem_opcode[rd_ptr];
    assign h_funct3 = mem_funct3[rd_ptr];
    assign h_funct7 = mem_funct7[rd_ptr];
    assign h_pc     = mem_pc[rd_ptr];
    assign h_data1  = mem_data1[rd_ptr];
    assign h_data2  = mem_data2[rd_ptr];
    assign h_imm    = mem_imm[rd_ptr];
    assign h_z      = mem_z[rd_ptr];

endmodule

`default_nettype wire

/* ex_stage.sv */
`default_nettype none

module ex_stage import ex_pkg::*; (
    input  wire logic        clk,
    input  wire logic        arst_n,
    input  wire opcode_e     h_opcode,
    input  wire logic [2:0]  h_funct3,
    input  wire logic [6:0]  h_funct7,
    input  wire word_t       h_pc,
    input  wire word_t       h_data1,
    input  wire word_t       h_data2,
    input  wire word_t       h_imm,
    input  wire word_t       h_z,
    input  wire logic        empty,
    input  wire logic        out_ack,
    output logic             pop,
    output logic             out_req,
    output word_t            out_result,
    output logic             out_taken
);

    typedef enum logic [1:0] {
        IDLE,
        REQ,
        WAIT_LOW
    } state_e;

    state_e     state;
    word_t      in1;
    word_t      in2;
    branch_op_e branch_alu_op;
    alu_op_e    alu_op;
    word_t      result;
    logic       taken;

    ex_ctrl i_ctrl (
        .opcode        (h_opcode),
        .funct3        (h_funct3),
        .funct7        (h_funct7),
        .data1         (h_data1),
        .data2         (h_data2),
        .pc            (h_pc),
        .imm           (h_imm),
        .z_            (h_z),
        .in1           (in1),
        .in2           (in2),
        .branch_alu_op (branch_alu_op),
        .alu_op        (alu_op)
    );

    ex_alu i_alu (
        .alu_op        (alu_op),
        .branch_alu_op (branch_alu_op),
        .in1           (in1),
        .in2           (in2),
        .cmp1          (h_data1),
        .cmp2          (h_data2),
        .result        (result),
        .taken         (taken)
    );

    // Take the head only with the output handshake fully released
    assign pop     = (state == IDLE) && !out_ack && !empty;
    assign out_req = (state == REQ);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:     if (pop) state <= REQ;
                REQ:      if (out_ack) state <= WAIT_LOW;
                WAIT_LOW: if (!out_ack) state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Output payload stays put for the whole handshake
    always_ff @(posedge clk) begin
        if (pop) begin
            out_result <= result;
            out_taken  <= taken;
        end
    end

endmodule

`default_nettype wire

/* ex_top.sv */
`default_nettype none

module ex_top import ex_pkg::*; (
    input  wire logic   clk,
    input  wire logic   arst_n,
    input  wire logic   in_req,
    output logic        in_ack,
    input  wire word_t  in_instr,
    input  wire word_t  in_pc,
    input  wire word_t  in_rs1,
    input  wire word_t  in_rs2,
    input  wire word_t  in_csr,
    output logic        out_req,
    input  wire logic   out_ack,
    output word_t       out_result,
    output logic        out_taken
);

    // Intake to queue
    logic       push;
    logic       full;
    opcode_e    q_opcode;
    logic [2:0] q_funct3;
    logic [6:0] q_funct7;
    word_t      q_pc;
    word_t      q_data1;
    word_t      q_data2;
    word_t      q_imm;
    word_t      q_z;

    // Queue head to execute
    logic       pop;
    logic       empty;
    opcode_e    h_opcode;
    logic [2:0] h_funct3;
    logic [6:0] h_funct7;
    word_t      h_pc;
    word_t      h_data1;
    word_t      h_data2;
    word_t      h_imm;
    word_t      h_z;

    ex_issue i_issue (
        .clk      (clk),
        .arst_n   (arst_n),
        .in_req   (in_req),
        .in_instr (in_instr),
        .in_pc    (in_pc),
        .in_rs1   (in_rs1),
        .in_rs2   (in_rs2),
        .in_csr   (in_csr),
        .full     (full),
        .in_ack   (in_ack),
        .push     (push),
        .q_opcode (q_opcode),
        .q_funct3 (q_funct3),
        .q_funct7 (q_funct7),
        .q_pc     (q_pc),
        .q_data1  (q_data1),
        .q_data2  (q_data2),
        .q_imm    (q_imm),
        .q_z      (q_z)
    );

    ex_queue i_queue (
        .clk      (clk),
        .arst_n   (arst_n),
        .push     (push),
        .pop      (pop),
        .q_opcode (q_opcode),
        .q_funct3 (q_funct3),
        .q_funct7 (q_funct7),
        .q_pc     (q_pc),
        .q_data1  (q_data1),
        .q_data2  (q_data2),
        .q_imm    (q_imm),
        .q_z      (q_z),
        .h_opcode (h_opcode),
        .h_funct3 (h_funct3),
        .h_funct7 (h_funct7),
        .h_pc     (h_pc),
        .h_data1  (h_data1),
        .h_data2  (h_data2),
        .h_imm    (h_imm),
        .h_z      (h_z),
        .full     (full),
        .empty    (empty)
    );

    ex_stage i_stage (
        .clk        (clk),
        .arst_n     (arst_n),
        .h_opcode   (h_opcode),
        .h_funct3   (h_funct3),
        .h_funct7   (h_funct7),
        .h_pc       (h_pc),
        .h_data1    (h_data1),
        .h_data2    (h_data2),
        .h_imm      (h_imm),
        .h_z        (h_z),
        .empty      (empty),
        .out_ack    (out_ack),
        .pop        (pop),
        .out_req    (out_req),
        .out_result (out_result),
        .out_taken  (out_taken)
    );

endmodule

`default_nettype wire

/* filelist.f */
ex_pkg.sv
ex_alu.sv
ex_ctrl.sv
ex_issue.sv
ex_queue.sv
ex_stage.sv
ex_top.sv
tb_clock.sv
tb_ex_top.sv

/* run.sh */
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_ex_top -f filelist.f -o tb_ex_top_sim

./obj_dir/tb_ex_top_sim 2>&1 | tee sim.log

if grep -q "^STATUS: PASS$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb_clock.sv */
`default_nettype none

module tb_clock (
    output logic clk
);

    // Period of 20 time units
    localparam int HALF_PERIOD = 10;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

endmodule

`default_nettype wire

/* tb_ex_top.sv */
`default_nettype none

module tb_ex_top import ex_pkg::*; ();

    localparam int RESET_CYCLES     = 10;
    localparam int NUM_ALU          = 300;
    localparam int NUM_MISC         = 60;
    localparam int NUM_BR_DIRECT    = 24;
    localparam int NUM_BR_RAND      = 36;
    localparam int NUM_CSR          = 48;
    localparam int TOTAL            = NUM_ALU + NUM_MISC + NUM_BR_DIRECT + NUM_BR_RAND + NUM_CSR;
    localparam int CYCLES_PER_INSTR = 200;
    localparam logic [31:0] LFSR_SEED = 32'hf6f2_5b67;
    localparam word_t SIGN_BIT      = 32'h8000_0000;

    logic  clk;
    logic  arst_n;
    logic  in_req;
    logic  in_ack;
    word_t in_instr;
    word_t in_pc;
    word_t in_rs1;
    word_t in_rs2;
    word_t in_csr;
    logic  out_req;
    logic  out_ack;
    word_t out_result;
    logic  out_taken;

    logic [31:0] lfsr_state;

    // Pre-built stimulus with one entry per instruction
    word_t      stim_instr [TOTAL];
    word_t      stim_pc    [TOTAL];
    word_t      stim_rs1   [TOTAL];
    word_t      stim_rs2   [TOTAL];
    word_t      stim_csr   [TOTAL];
    logic [2:0] ack_delay  [TOTAL];

    int stim_count;
    int num_sent;
    int num_checked;
    int stall_count;
    int sink_index;

    // Expected values in send order
    word_t exp_result_q [$];
    logic  exp_taken_q  [$];
    word_t exp_instr_q  [$];

    tb_clock i_clock (
        .clk (clk)
    );

    ex_top i_dut (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .in_instr   (in_instr),
        .in_pc      (in_pc),
        .in_rs1     (in_rs1),
        .in_rs2     (in_rs2),
        .in_csr     (in_csr),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_result (out_result),
        .out_taken  (out_taken)
    );

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t take_bits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // Random instruction of one opcode with legal funct3 and funct7
    function automatic word_t make_instr(input opcode_e op);
        word_t      instr;
        word_t      rnd;
        logic [2:0] sel;
        instr = take_bits(32);
        rnd = take_bits(3);
        sel = rnd[2:0];
        instr[6:0] = op;
        case (op)
            OP_R_TYPE: begin
                instr[31:25] = 7'b0000000;
                if (instr[14:12] == 3'b000 || instr[14:12] == 3'b101)
                    instr[30] = sel[0];
            end
            OP_I_TYPE: begin
                if (instr[14:12] == 3'b001)
                    instr[31:25] = 7'b0000000;
                else if (instr[14:12] == 3'b101)
                    instr[31:25] = {1'b0, sel[0], 5'b00000};
            end
            OP_JALR:   instr[14:12] = 3'b000;
            OP_LOAD:   instr[14:12] = (sel == 3'd3 || sel[2:1] == 2'b11) ? 3'b010 : sel;
            OP_STORE:  instr[14:12] = (sel[1:0] == 2'b11) ? 3'b010 : {1'b0, sel[1:0]};
            OP_BRANCH: instr[14:12] = (sel[2:1] == 2'b01) ? {1'b1, sel[1:0]} : sel;
            OP_SYSTEM: instr[14:12] = (sel[1:0] == 2'b00) ? {sel[2], 2'b01} : sel;
            default:   instr[14:12] = sel;
        endcase
        return instr;
    endfunction

    // RV32I integer op where alt selects SUB and SRA
    function automatic word_t int_op(input logic [2:0] f3, input logic alt,
                                     input word_t a, input word_t b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'b011:  return (a < b) ? 32'd1 : 32'd0;
            3'b100:  return a ^ b;
            3'b101:  return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branch_outcome(input logic [2:0] f3, input word_t a,
                                            input word_t b);
        case (f3)
            3'b000:  return a == b;
            3'b001:  return a != b;
            3'b100:  return $signed(a) < $signed(b);
            3'b101:  return $signed(a) >= $signed(b);
            3'b110:  return a < b;
            default: return a >= b;
        endcase
    endfunction

    // Expected result and taken of one instruction
    function automatic void reference_model(input word_t instr, input word_t pc,
                                            input word_t rs1, input word_t rs2,
                                            input word_t csr, output word_t result,
                                            output logic taken);
        opcode_e    op;
        logic [2:0] f3;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      operand;
        op    = opcode_e'(instr[6:0]);
        f3    = instr[14:12];
        imm_i = {{20{instr[31]}}, instr[31:20]};
        imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
        imm_u = {instr[31:12], 12'h000};
        imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
        result = '0;
        taken  = 1'b0;
        case (op)
            OP_LUI:    result = imm_u;
            OP_AUIPC:  result = pc + imm_u;
            OP_JAL: begin
                result = pc + imm_j;
                taken  = 1'b1;
            end
            OP_JALR: begin
                result = (rs1 + imm_i) & 32'hffff_fffe;
                taken  = 1'b1;
            end
            OP_LOAD:   result = rs1 + imm_i;
            OP_STORE:  result = rs1 + imm_s;
            OP_BRANCH: begin
                result = pc + imm_b;
                taken  = branch_outcome(f3, rs1, rs2);
            end
            // Only the shift right has an alternate form with an immediate
            OP_I_TYPE: result = int_op(f3, (f3 == 3'b101) && instr[30], rs1, imm_i);
            OP_R_TYPE: result = int_op(f3, instr[30], rs1, rs2);
            OP_SYSTEM: begin
                operand = f3[2] ? {27'd0, instr[19:15]} : rs1;
                case (f3[1:0])
                    2'b01:   result = operand;
                    2'b10:   result = csr | operand;
                    default: result = csr & ~operand;
                endcase
            end
            default:   result = '0;
        endcase
    endfunction

    task automatic check_result(input word_t got, input word_t exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %08h, expected %08h",
                     $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "result mismatch");
        end
    endtask

    task automatic check_taken(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s, got %b, expected %b",
                     $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "taken mismatch");
        end
    endtask

    task automatic check_level(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("CHECK FAILED at time %0t: %s is %b, expected %b",
                     $time, what, got, exp);
            $display("STATUS: FAIL");
            $fatal(1, "handshake level mismatch");
        end
    endtask

    task automatic add_stim(input word_t instr, input word_t rs1, input word_t rs2);
        word_t rnd;
        stim_instr[stim_count] = instr;
        stim_rs1[stim_count]   = rs1;
        stim_rs2[stim_count]   = rs2;
        rnd = take_bits(30);
        stim_pc[stim_count]    = {rnd[29:0], 2'b00};
        stim_csr[stim_count]   = take_bits(32);
        rnd = take_bits(3);
        ack_delay[stim_count]  = rnd[2:0];
        stim_count++;
    endtask

    task automatic build_stimulus();
        word_t      instr;
        word_t      rnd;
        word_t      a;
        word_t      b;
        opcode_e    op;
        logic [2:0] f3;
        int         i;
        int         k;
        // Register and immediate arithmetic
        for (i = 0; i < NUM_ALU; i++) begin
            rnd = take_bits(1);
            instr = make_instr(rnd[0] ? OP_R_TYPE : OP_I_TYPE);
            a = take_bits(32);
            b = take_bits(32);
            add_stim(instr, a, b);
        end
        // Upper immediates, jumps, loads and stores
        for (i = 0; i < NUM_MISC; i++) begin
            case (i % 6)
                0:       op = OP_LUI;
                1:       op = OP_AUIPC;
                2:       op = OP_JAL;
                3:       op = OP_JALR;
                4:       op = OP_LOAD;
                default: op = OP_STORE;
            endcase
            instr = make_instr(op);
            a = take_bits(32);
            b = take_bits(32);
            add_stim(instr, a, b);
        end
        // Each branch with equal operands and operands apart only in the sign bit
        for (k = 0; k < 6; k++) begin
            f3 = 3'((k < 2) ? k : k + 2);
            a = take_bits(32) & 32'h7fff_ffff;
            b = take_bits(32);
            instr = make_instr(OP_BRANCH);
            instr[14:12] = f3;
            add_stim(instr, a, a);
            add_stim(instr, a, a | SIGN_BIT);
            add_stim(instr, a | SIGN_BIT, a);
            add_stim(instr, a, b);
        end
        for (i = 0; i < NUM_BR_RAND; i++) begin
            instr = make_instr(OP_BRANCH);
            rnd = take_bits(2);
            a = take_bits(32);
            case (rnd[1:0])
                2'b00:   b = a;
                2'b01:   b = a ^ SIGN_BIT;
                default: b = take_bits(32);
            endcase
            add_stim(instr, a, b);
        end
        // CSRRW, CSRRS, CSRRC and their immediate forms
        for (k = 0; k < 6; k++) begin
            f3 = 3'((k < 3) ? k + 1 : k + 2);
            for (i = 0; i < NUM_CSR / 6; i++) begin
                instr = make_instr(OP_SYSTEM);
                instr[14:12] = f3;
                a = take_bits(32);
                b = take_bits(32);
                add_stim(instr, a, b);
            end
        end
    endtask

    // Four-phase source started just after a falling edge
    task automatic send_instr(input int k);
        word_t exp_r;
        logic  exp_t;
        reference_model(stim_instr[k], stim_pc[k], stim_rs1[k], stim_rs2[k],
                        stim_csr[k], exp_r, exp_t);
        exp_result_q.push_back(exp_r);
        exp_taken_q.push_back(exp_t);
        exp_instr_q.push_back(stim_instr[k]);
        in_instr = stim_instr[k];
        in_pc    = stim_pc[k];
        in_rs1   = stim_rs1[k];
        in_rs2   = stim_rs2[k];
        in_csr   = stim_csr[k];
        in_req   = 1'b1;
        @(negedge clk);
        // Ack later than one cycle means the queue pushed back
        if (!in_ack)
            stall_count++;
        while (!in_ack)
            @(negedge clk);
        in_req = 1'b0;
        @(negedge clk);
        while (in_ack)
            @(negedge clk);
        num_sent++;
    endtask

    initial begin
        arst_n      = 1'b0;
        in_req      = 1'b0;
        in_instr    = '0;
        in_pc       = '0;
        in_rs1      = '0;
        in_rs2      = '0;
        in_csr      = '0;
        lfsr_state  = LFSR_SEED;
        stim_count  = 0;
        num_sent    = 0;
        stall_count = 0;
        build_stimulus();
        repeat (RESET_CYCLES) @(negedge clk);
        check_level(in_ack, 1'b0, "in_ack during reset");
        check_level(out_req, 1'b0, "out_req during reset");
        arst_n = 1'b1;
        @(negedge clk);
        check_level(in_ack, 1'b0, "in_ack after reset");
        check_level(out_req, 1'b0, "out_req after reset");
        for (int k = 0; k < TOTAL; k++)
            send_instr(k);
        while (num_checked < TOTAL)
            @(negedge clk);
        // Quiet period in which a stray output would show up
        repeat (20) @(negedge clk);
        if (stall_count > 0) begin
            $display("STATUS: PASS");
            $finish;
        end else begin
            $display("The queue never held back in_ack during %0d instructions", TOTAL);
            $display("STATUS: FAIL");
            $fatal(1, "no back-pressure seen");
        end
    end

    // Sink answers each output request after its chosen delay
    initial begin
        out_ack    = 1'b0;
        sink_index = 0;
        wait (arst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (out_req && !out_ack) begin
                repeat (ack_delay[sink_index % TOTAL]) @(negedge clk);
                sink_index++;
                out_ack = 1'b1;
                @(negedge clk);
                while (out_req)
                    @(negedge clk);
                out_ack = 1'b0;
            end
        end
    end

    // Compare on each rising out_req
    initial begin
        logic  prev_req;
        word_t exp_r;
        logic  exp_t;
        word_t instr;
        prev_req    = 1'b0;
        num_checked = 0;
        forever begin
            @(negedge clk);
            if (out_req && !prev_req) begin
                if (exp_result_q.size() == 0) begin
                    $display("Output request at time %0t with no instruction pending", $time);
                    $display("STATUS: FAIL");
                    $fatal(1, "unexpected output");
                end else begin
                    exp_r = exp_result_q.pop_front();
                    exp_t = exp_taken_q.pop_front();
                    instr = exp_instr_q.pop_front();
                    check_result(out_result, exp_r,
                                 $sformatf("result of #%0d instr %08h", num_checked, instr));
                    check_taken(out_taken, exp_t,
                                $sformatf("taken of #%0d instr %08h", num_checked, instr));
                    num_checked++;
                end
            end
            prev_req = out_req;
        end
    end

    // Watchdog sized by the number of instructions
    initial begin
        repeat (RESET_CYCLES + CYCLES_PER_INSTR * TOTAL) @(posedge clk);
        $display("Timeout: the run hung waiting for a handshake, %0d sent, %0d checked",
                 num_sent, num_checked);
        $display("STATUS: FAIL");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire
